/* include/rbus_consts.svh */
//----------------------------------------------------------------------------
// Result bus widths and per-pipe source counts
//----------------------------------------------------------------------------
`ifndef RBUS_CONSTS_SVH
`define RBUS_CONSTS_SVH

// Result payload and register file geometry
`define RBUS_DATA_W      64
`define RBUS_PREG_W      7
`define RBUS_PREG_NUM    96

// Execution units feeding each write-back pipe
`define RBUS_P0_SRC_NUM  3
`define RBUS_P1_SRC_NUM  2

`endif

/* hdl/rbus_pkg.sv */
//----------------------------------------------------------------------------
// Result bus types: register number, data, one-hot vector, source offer
// and the source slot names of both pipes
//----------------------------------------------------------------------------
`include "rbus_consts.svh"

package rbus_pkg;

  // Physical register number and its one-hot form
  typedef logic [`RBUS_PREG_W-1:0]   rbus_preg_t;
  typedef logic [`RBUS_PREG_NUM-1:0] rbus_expand_t;

  // Result value
  typedef logic [`RBUS_DATA_W-1:0]   rbus_data_t;

  // One execution unit's offer to a pipe, 72 bits
  typedef struct packed {
    logic       valid;
    rbus_preg_t preg;
    rbus_data_t data;
  } rbus_rslt_t;

  // Pipe 0 slots, ALU always first
  typedef enum logic [1:0] {
    SRC0_ALU     = 2'd0,
    SRC0_DIV     = 2'd1,
    SRC0_SPECIAL = 2'd2
  } rbus_p0_src_e;

  // Pipe 1 slots
  typedef enum logic {
    SRC1_ALU  = 1'b0,
    SRC1_MULT = 1'b1
  } rbus_p1_src_e;

endpackage

/* hdl/rbus_src_arb.sv */
//----------------------------------------------------------------------------
// Source arbiter for one write-back pipe: one-hot select of the valid
// offer, with the debug write-back-buffer override on the ALU slot
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "rbus_consts.svh"

module rbus_src_arb #(
  parameter int NUM_SRC = `RBUS_P0_SRC_NUM
) (
  input  rbus_pkg::rbus_rslt_t src [NUM_SRC],
  input  logic                 wbbr_vld,
  input  rbus_pkg::rbus_data_t wbbr_data,
  output logic                 rslt_vld,
  output rbus_pkg::rbus_preg_t rslt_preg,
  output rbus_pkg::rbus_data_t rslt_data
);

  import rbus_pkg::*;

  logic [NUM_SRC-1:0] src_vld;
  rbus_data_t         alu_data;

  //--------------------------------------------------------------------------
  // ALU data after write-back buffer
  //--------------------------------------------------------------------------
  // Slot 0 is the ALU in both pipes
  assign alu_data = wbbr_vld ? wbbr_data : src[0].data;

  //--------------------------------------------------------------------------
  // AND-OR select
  //--------------------------------------------------------------------------
  // Only one slot may be valid, so OR-ing the gated fields is the mux.
  // Several valid slots give a meaningless mix
  always_comb
  begin
    rslt_preg = '0;
    rslt_data = '0;
    for (int i = 0; i < NUM_SRC; i++)
    begin
      src_vld[i] = src[i].valid;
      if (src[i].valid)
      begin
        rslt_preg = rslt_preg | src[i].preg;
        if (i == 0)
          rslt_data = rslt_data | alu_data;
        else
          rslt_data = rslt_data | src[i].data;
      end
    end
  end

  // Any offer makes a write-back
  assign rslt_vld = |src_vld;

endmodule

/* hdl/rbus_preg_expand.sv */
//----------------------------------------------------------------------------
// Decoder from a physical register number to a one-hot register vector
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "rbus_consts.svh"

module rbus_preg_expand (
  input  rbus_pkg::rbus_preg_t   preg,
  output rbus_pkg::rbus_expand_t preg_expand
);

  import rbus_pkg::*;

  // Numbers past the register file decode to all zeros
  always_comb
  begin
    preg_expand = '0;
    for (int n = 0; n < `RBUS_PREG_NUM; n++)
    begin
      if (preg == rbus_preg_t'(n))
        preg_expand[n] = 1'b1;
    end
  end

endmodule

/* hdl/rbus_wb_reg.sv */
//----------------------------------------------------------------------------
// Write-back registers of one pipe: valid with flush kill, register
// number, one-hot vector and data held between offers
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module rbus_wb_reg (
  input  logic                   rslt_vld_clk,
  input  logic                   cpurst_b,
  input  logic                   flush,
  input  logic                   rslt_vld,
  input  rbus_pkg::rbus_preg_t   rslt_preg,
  input  rbus_pkg::rbus_data_t   rslt_data,
  output logic                   wb_vld,
  output rbus_pkg::rbus_preg_t   wb_preg,
  output rbus_pkg::rbus_expand_t wb_expand,
  output rbus_pkg::rbus_data_t   wb_data
);

  import rbus_pkg::*;

  rbus_expand_t rslt_expand;

  // Decode ahead of the register so the vector is ready with wb_preg
  rbus_preg_expand u_preg_expand (
    .preg        (rslt_preg),
    .preg_expand (rslt_expand)
  );

  //--------------------------------------------------------------------------
  // Write-back valid
  //--------------------------------------------------------------------------
  always_ff @(posedge rslt_vld_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wb_vld <= 1'b0;
    else if (flush)
      wb_vld <= 1'b0;
    else
      wb_vld <= rslt_vld;
  end

  //--------------------------------------------------------------------------
  // Write-back payload
  //--------------------------------------------------------------------------
  // Loads on any offer, flushed or not, and holds otherwise
  always_ff @(posedge rslt_vld_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wb_preg   <= '0;
      wb_expand <= '0;
      wb_data   <= '0;
    end
    else if (rslt_vld)
    begin
      wb_preg   <= rslt_preg;
      wb_expand <= rslt_expand;
      wb_data   <= rslt_data;
    end
  end

endmodule

/* hdl/iu_rbus_top.sv */
//----------------------------------------------------------------------------
// Integer unit result bus: two write-back pipes, ALU forward path and
// the multiplier late data select
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "rbus_consts.svh"

module iu_rbus_top (
  input  logic                   rslt_vld_clk,
  input  logic                   cpurst_b,
  input  logic                   rtu_flush,
  // Debug write-back buffer
  input  logic                   wbbr_vld,
  input  rbus_pkg::rbus_data_t   wbbr_data,
  // Pipe 0 sources
  input  logic                   alu0_vld,
  input  rbus_pkg::rbus_preg_t   alu0_preg,
  input  rbus_pkg::rbus_data_t   alu0_data,
  input  logic                   alu0_fwd_vld,
  input  rbus_pkg::rbus_data_t   alu0_fwd_data,
  input  logic                   div_vld,
  input  rbus_pkg::rbus_preg_t   div_preg,
  input  rbus_pkg::rbus_data_t   div_data,
  input  logic                   special_vld,
  input  rbus_pkg::rbus_preg_t   special_preg,
  input  rbus_pkg::rbus_data_t   special_data,
  // Pipe 1 sources
  input  logic                   alu1_vld,
  input  rbus_pkg::rbus_preg_t   alu1_preg,
  input  rbus_pkg::rbus_data_t   alu1_data,
  input  logic                   alu1_fwd_vld,
  input  rbus_pkg::rbus_data_t   alu1_fwd_data,
  input  logic                   mult_ex3_vld,
  input  rbus_pkg::rbus_preg_t   mult_ex3_preg,
  input  logic                   mult_ex4_vld,
  input  rbus_pkg::rbus_data_t   mult_ex4_data,
  // EX1 forward
  output logic                   p0_fwd_vld,
  output rbus_pkg::rbus_preg_t   p0_fwd_preg,
  output rbus_pkg::rbus_data_t   p0_fwd_data,
  output logic                   p1_fwd_vld,
  output rbus_pkg::rbus_preg_t   p1_fwd_preg,
  output rbus_pkg::rbus_data_t   p1_fwd_data,
  // Write-back
  output logic                   p0_wb_vld,
  output rbus_pkg::rbus_preg_t   p0_wb_preg,
  output rbus_pkg::rbus_expand_t p0_wb_expand,
  output rbus_pkg::rbus_data_t   p0_wb_data,
  output logic                   p1_wb_vld,
  output rbus_pkg::rbus_preg_t   p1_wb_preg,
  output rbus_pkg::rbus_expand_t p1_wb_expand,
  output rbus_pkg::rbus_data_t   p1_wb_data
);

  import rbus_pkg::*;

  rbus_rslt_t p0_src [`RBUS_P0_SRC_NUM];
  rbus_rslt_t p1_src [`RBUS_P1_SRC_NUM];
  logic       p0_rslt_vld;
  rbus_preg_t p0_rslt_preg;
  rbus_data_t p0_rslt_data;
  logic       p1_rslt_vld;
  rbus_preg_t p1_rslt_preg;
  rbus_data_t p1_rslt_data;
  rbus_data_t p1_wb_data_q;

  //--------------------------------------------------------------------------
  // Pipe 0
  //--------------------------------------------------------------------------
  assign p0_src[SRC0_ALU]     = '{valid: alu0_vld, preg: alu0_preg, data: alu0_data};
  assign p0_src[SRC0_DIV]     = '{valid: div_vld, preg: div_preg, data: div_data};
  assign p0_src[SRC0_SPECIAL] = '{valid: special_vld, preg: special_preg,
                                  data: special_data};

  rbus_src_arb #(.NUM_SRC(`RBUS_P0_SRC_NUM)) u_p0_arb (
    .src       (p0_src),
    .wbbr_vld  (wbbr_vld),
    .wbbr_data (wbbr_data),
    .rslt_vld  (p0_rslt_vld),
    .rslt_preg (p0_rslt_preg),
    .rslt_data (p0_rslt_data)
  );

  rbus_wb_reg u_p0_wb (
    .rslt_vld_clk (rslt_vld_clk),
    .cpurst_b     (cpurst_b),
    .flush        (rtu_flush),
    .rslt_vld     (p0_rslt_vld),
    .rslt_preg    (p0_rslt_preg),
    .rslt_data    (p0_rslt_data),
    .wb_vld       (p0_wb_vld),
    .wb_preg      (p0_wb_preg),
    .wb_expand    (p0_wb_expand),
    .wb_data      (p0_wb_data)
  );

  //--------------------------------------------------------------------------
  // Pipe 1
  //--------------------------------------------------------------------------
  // Multiplier register number comes in EX3, its data only in EX4
  assign p1_src[SRC1_ALU]  = '{valid: alu1_vld, preg: alu1_preg, data: alu1_data};
  assign p1_src[SRC1_MULT] = '{valid: mult_ex3_vld, preg: mult_ex3_preg,
                               data: mult_ex4_data};

  rbus_src_arb #(.NUM_SRC(`RBUS_P1_SRC_NUM)) u_p1_arb (
    .src       (p1_src),
    .wbbr_vld  (wbbr_vld),
    .wbbr_data (wbbr_data),
    .rslt_vld  (p1_rslt_vld),
    .rslt_preg (p1_rslt_preg),
    .rslt_data (p1_rslt_data)
  );

  rbus_wb_reg u_p1_wb (
    .rslt_vld_clk (rslt_vld_clk),
    .cpurst_b     (cpurst_b),
    .flush        (rtu_flush),
    .rslt_vld     (p1_rslt_vld),
    .rslt_preg    (p1_rslt_preg),
    .rslt_data    (p1_rslt_data),
    .wb_vld       (p1_wb_vld),
    .wb_preg      (p1_wb_preg),
    .wb_expand    (p1_wb_expand),
    .wb_data      (p1_wb_data_q)
  );

  // Late multiplier data bypasses the data register
  assign p1_wb_data = mult_ex4_vld ? mult_ex4_data : p1_wb_data_q;

  //--------------------------------------------------------------------------
  // EX1 forward path, ALUs only
  //--------------------------------------------------------------------------
  assign p0_fwd_vld  = alu0_fwd_vld;
  assign p0_fwd_preg = alu0_preg;
  assign p0_fwd_data = alu0_fwd_data;
  assign p1_fwd_vld  = alu1_fwd_vld;
  assign p1_fwd_preg = alu1_preg;
  assign p1_fwd_data = alu1_fwd_data;

endmodule

/* tests/rbus_asserts.sv */
//----------------------------------------------------------------------------
// Concurrent checks on the source arbiters and write-back registers,
// bound into the result bus top level
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "rbus_consts.svh"

module rbus_asserts (
  input logic                   clk,
  input logic                   rst_b,
  input logic                   flush,
  input logic                   alu0_vld,
  input logic                   div_vld,
  input logic                   special_vld,
  input logic                   alu1_vld,
  input logic                   mult_ex3_vld,
  input logic                   p0_wb_vld,
  input logic                   p1_wb_vld,
  input rbus_pkg::rbus_preg_t   p0_wb_preg,
  input rbus_pkg::rbus_preg_t   p1_wb_preg,
  input rbus_pkg::rbus_expand_t p0_wb_expand,
  input rbus_pkg::rbus_expand_t p1_wb_expand
);

  import rbus_pkg::*;

  // One offer per pipe and cycle
  a_p0_one_src: assert property (@(posedge clk) disable iff (!rst_b)
    $onehot0({alu0_vld, div_vld, special_vld}))
    else $error("Pipe 0 arbiter saw more than one valid source");
  a_p1_one_src: assert property (@(posedge clk) disable iff (!rst_b)
    $onehot0({alu1_vld, mult_ex3_vld}))
    else $error("Pipe 1 arbiter saw more than one valid source");

  // Flush kills both write-backs at the next edge
  a_flush_kill: assert property (@(posedge clk) disable iff (!rst_b)
    flush |=> !p0_wb_vld && !p1_wb_vld)
    else $error("Write-back valid high after a flush");

  //--------------------------------------------------------------------------
  // One-hot vector against register number
  //--------------------------------------------------------------------------
  a_p0_expand: assert property (@(posedge clk) disable iff (!rst_b)
    p0_wb_vld |-> ((int'(p0_wb_preg) < `RBUS_PREG_NUM) ?
      (p0_wb_expand == (rbus_expand_t'(1) << p0_wb_preg)) : (p0_wb_expand == '0)))
    else $error("Pipe 0 one-hot vector does not match register number");
  a_p1_expand: assert property (@(posedge clk) disable iff (!rst_b)
    p1_wb_vld |-> ((int'(p1_wb_preg) < `RBUS_PREG_NUM) ?
      (p1_wb_expand == (rbus_expand_t'(1) << p1_wb_preg)) : (p1_wb_expand == '0)))
    else $error("Pipe 1 one-hot vector does not match register number");

endmodule

bind iu_rbus_top rbus_asserts u_asserts (
  .clk          (rslt_vld_clk),
  .rst_b        (cpurst_b),
  .flush        (rtu_flush),
  .alu0_vld     (alu0_vld),
  .div_vld      (div_vld),
  .special_vld  (special_vld),
  .alu1_vld     (alu1_vld),
  .mult_ex3_vld (mult_ex3_vld),
  .p0_wb_vld    (p0_wb_vld),
  .p1_wb_vld    (p1_wb_vld),
  .p0_wb_preg   (p0_wb_preg),
  .p1_wb_preg   (p1_wb_preg),
  .p0_wb_expand (p0_wb_expand),
  .p1_wb_expand (p1_wb_expand)
);

/* tests/rbus_tb.sv */
//----------------------------------------------------------------------------
// Result bus testbench: clock, reset, watchdog, compare tasks and
// directed tests of both write-back pipes
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "rbus_consts.svh"

module rbus_tb;

  import rbus_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 8;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 40;
  localparam int UNIT_ALU0       = 0;
  localparam int UNIT_DIV        = 1;
  localparam int UNIT_SPECIAL    = 2;
  localparam int UNIT_ALU1       = 3;

  logic         rslt_vld_clk = 1'b0;
  logic         cpurst_b = 1'b0, rtu_flush = 1'b0, wbbr_vld = 1'b0;
  logic         alu0_vld = 1'b0, alu0_fwd_vld = 1'b0, div_vld = 1'b0, special_vld = 1'b0;
  logic         alu1_vld = 1'b0, alu1_fwd_vld = 1'b0, mult_ex3_vld = 1'b0, mult_ex4_vld = 1'b0;
  rbus_preg_t   alu0_preg = '0, div_preg = '0, special_preg = '0;
  rbus_preg_t   alu1_preg = '0, mult_ex3_preg = '0;
  rbus_data_t   wbbr_data = '0, alu0_data = '0, alu0_fwd_data = '0, div_data = '0;
  rbus_data_t   special_data = '0, alu1_data = '0, alu1_fwd_data = '0, mult_ex4_data = '0;
  logic         p0_fwd_vld, p1_fwd_vld, p0_wb_vld, p1_wb_vld;
  rbus_preg_t   p0_fwd_preg, p1_fwd_preg, p0_wb_preg, p1_wb_preg;
  rbus_data_t   p0_fwd_data, p1_fwd_data, p0_wb_data, p1_wb_data;
  rbus_expand_t p0_wb_expand, p1_wb_expand;
  int           seed = 66;
  int           vld_errs = 0, preg_errs = 0, expand_errs = 0, data_errs = 0;

  iu_rbus_top u_dut (.*);

  always #(CLK_PERIOD / 2) rslt_vld_clk = ~rslt_vld_clk;

  // Watchdog sized from the test count
  initial
  begin
    #((RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD);
    $display("Watchdog expired before all tests completed");
    $display("ERRORS FOUND");
    $finish;
  end

  //--------------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------------
  task automatic check_vld(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      vld_errs++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_preg(input string what, input rbus_preg_t got, input rbus_preg_t exp);
    if (got !== exp)
    begin
      preg_errs++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_expand(input string what, input rbus_expand_t got,
                              input rbus_expand_t exp);
    if (got !== exp)
    begin
      expand_errs++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input string what, input rbus_data_t got, input rbus_data_t exp);
    if (got !== exp)
    begin
      data_errs++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  //--------------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------------
  // Bit n set for register n, nothing past the register file
  function automatic rbus_expand_t onehot_of(input rbus_preg_t preg);
    rbus_expand_t vec;
    vec = '0;
    if (int'(preg) < `RBUS_PREG_NUM)
      vec[preg] = 1'b1;
    return vec;
  endfunction

  function automatic rbus_data_t rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic next_cycle();
    @(posedge rslt_vld_clk);
    #1;
  endtask

  task automatic idle_strobes();
    alu0_vld     = 1'b0;
    div_vld      = 1'b0;
    special_vld  = 1'b0;
    alu1_vld     = 1'b0;
    mult_ex3_vld = 1'b0;
    mult_ex4_vld = 1'b0;
    rtu_flush    = 1'b0;
    wbbr_vld     = 1'b0;
  endtask

  // Idle units carry inverted values so a wrong select shows up
  task automatic drive_offer(input int unit, input rbus_preg_t preg, input rbus_data_t data);
    alu0_vld     = (unit == UNIT_ALU0);
    div_vld      = (unit == UNIT_DIV);
    special_vld  = (unit == UNIT_SPECIAL);
    alu1_vld     = (unit == UNIT_ALU1);
    alu0_preg    = (unit == UNIT_ALU0) ? preg : ~preg;
    div_preg     = (unit == UNIT_DIV) ? preg : ~preg;
    special_preg = (unit == UNIT_SPECIAL) ? preg : ~preg;
    alu1_preg    = (unit == UNIT_ALU1) ? preg : ~preg;
    alu0_data    = (unit == UNIT_ALU0) ? data : ~data;
    div_data     = (unit == UNIT_DIV) ? data : ~data;
    special_data = (unit == UNIT_SPECIAL) ? data : ~data;
    alu1_data    = (unit == UNIT_ALU1) ? data : ~data;
  endtask

  task automatic check_pipe(input int pipe, input logic vld, input rbus_preg_t preg,
                            input rbus_data_t data);
    if (pipe == 0)
    begin
      check_vld("p0_wb_vld", p0_wb_vld, vld);
      check_preg("p0_wb_preg", p0_wb_preg, preg);
      check_expand("p0_wb_expand", p0_wb_expand, onehot_of(preg));
      check_data("p0_wb_data", p0_wb_data, data);
    end
    else
    begin
      check_vld("p1_wb_vld", p1_wb_vld, vld);
      check_preg("p1_wb_preg", p1_wb_preg, preg);
      check_expand("p1_wb_expand", p1_wb_expand, onehot_of(preg));
      check_data("p1_wb_data", p1_wb_data, data);
    end
  endtask

  task automatic offer_and_check(input int unit, input rbus_preg_t preg,
                                 input rbus_data_t data, input rbus_data_t exp_data);
    drive_offer(unit, preg, data);
    next_cycle();
    check_pipe((unit == UNIT_ALU1) ? 1 : 0, 1'b1, preg, exp_data);
    idle_strobes();
  endtask

  //--------------------------------------------------------------------------
  // Directed tests
  //--------------------------------------------------------------------------
  task automatic test_single_source();
    rbus_preg_t pregs [3];
    rbus_data_t data;
    pregs = '{7'd0, 7'd95, 7'd100};
    for (int u = UNIT_ALU0; u <= UNIT_ALU1; u++)
    begin
      for (int k = 0; k < 3; k++)
      begin
        data = rand_data();
        offer_and_check(u, pregs[k], data, data);
      end
    end
  endtask

  task automatic test_wbbr_override();
    rbus_data_t buf_data;
    rbus_data_t data;
    buf_data = rand_data();
    for (int u = UNIT_ALU0; u <= UNIT_ALU1; u++)
    begin
      data      = rand_data();
      wbbr_vld  = 1'b1;
      wbbr_data = buf_data;
      offer_and_check(u, rbus_preg_t'(u + 30), data,
                      (u == UNIT_ALU0 || u == UNIT_ALU1) ? buf_data : data);
    end
  endtask

  // Register number in EX3, data one cycle later in EX4
  task automatic test_mult_late_data();
    rbus_data_t data;
    data          = rand_data();
    mult_ex3_vld  = 1'b1;
    mult_ex3_preg = 7'd42;
    mult_ex4_data = ~data;
    next_cycle();
    mult_ex3_vld  = 1'b0;
    mult_ex4_vld  = 1'b1;
    mult_ex4_data = data;
    #1;
    check_pipe(1, 1'b1, 7'd42, data);
    idle_strobes();
  endtask

  task automatic test_flush_kill();
    rbus_data_t d0;
    rbus_data_t d1;
    d0 = rand_data();
    d1 = rand_data();
    drive_offer(UNIT_ALU0, 7'd17, d0);
    alu1_vld  = 1'b1;
    alu1_preg = 7'd63;
    alu1_data = d1;
    rtu_flush = 1'b1;
    next_cycle();
    check_pipe(0, 1'b0, 7'd17, d0);
    check_pipe(1, 1'b0, 7'd63, d1);
    idle_strobes();
  endtask

  task automatic test_hold();
    rbus_data_t d0;
    rbus_data_t d1;
    d0 = rand_data();
    d1 = rand_data();
    drive_offer(UNIT_DIV, 7'd88, d0);
    alu1_vld  = 1'b1;
    alu1_preg = 7'd5;
    alu1_data = d1;
    for (int c = 0; c < 3; c++)
    begin
      next_cycle();
      check_pipe(0, c == 0, 7'd88, d0);
      check_pipe(1, c == 0, 7'd5, d1);
      idle_strobes();
    end
  endtask

  task automatic test_forward();
    for (int k = 0; k < 2; k++)
    begin
      alu0_fwd_vld  = (k == 1);
      alu1_fwd_vld  = (k == 1);
      alu0_preg     = rbus_preg_t'($random(seed));
      alu1_preg     = rbus_preg_t'($random(seed));
      alu0_fwd_data = rand_data();
      alu1_fwd_data = rand_data();
      #1;
      check_vld("p0_fwd_vld", p0_fwd_vld, k == 1);
      check_preg("p0_fwd_preg", p0_fwd_preg, alu0_preg);
      check_data("p0_fwd_data", p0_fwd_data, alu0_fwd_data);
      check_vld("p1_fwd_vld", p1_fwd_vld, k == 1);
      check_preg("p1_fwd_preg", p1_fwd_preg, alu1_preg);
      check_data("p1_fwd_data", p1_fwd_data, alu1_fwd_data);
      next_cycle();
    end
    alu0_fwd_vld = 1'b0;
    alu1_fwd_vld = 1'b0;
  endtask

  initial
  begin
    repeat (RESET_CYCLES) @(posedge rslt_vld_clk);
    #1;
    cpurst_b = 1'b1;
    next_cycle();
    test_single_source();
    test_wbbr_override();
    test_mult_late_data();
    test_flush_kill();
    test_hold();
    test_forward();
    $display("Error counts: vld=%0d preg=%0d expand=%0d data=%0d", vld_errs, preg_errs,
             expand_errs, data_errs);
    if (vld_errs + preg_errs + expand_errs + data_errs == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* build.f */
+incdir+include
hdl/rbus_pkg.sv
hdl/rbus_src_arb.sv
hdl/rbus_preg_expand.sv
hdl/rbus_wb_reg.sv
hdl/iu_rbus_top.sv
tests/rbus_asserts.sv
tests/rbus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the result bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module rbus_tb \
  --Mdir obj_dir -o rbus_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/rbus_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1
